/* build.f */
+incdir+rtl
rtl/icache_pkg.sv
rtl/icache_array.sv
rtl/icache_way_select.sv
rtl/icache_ctrl.sv
rtl/icache_top.sv
verif/icache_tb.sv

/* Bender.yml */
package:
  name: icache

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/icache_pkg.sv
      - rtl/icache_array.sv
      - rtl/icache_way_select.sv
      - rtl/icache_ctrl.sv
      - rtl/icache_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verif/icache_tb.sv

/* verif/icache_tests.txt */
# Columns: command, argument A (hex), argument B (hex)
# B bypass | F flush | L addr flag(0 miss 1 hit 2 either) | S base count | I cycles | R max refills
B 00000001 0
L 00001234 0
L 0000456c 0
L 00001234 0
R 00000003 0
# Enable with a full flush, then fill four sets
B 00000000 0
L 00000100 0
L 00000104 1
L 00000110 0
L 00000120 0
L 0000013c 0
L 00000128 1
S 00000100 4
I 00000005 0
R 00000004 0
# Five lines in set 5 share four ways
L 00000050 0
L 00000150 0
L 00000250 0
L 00000350 0
L 00000450 0
L 00000450 2
L 00000350 2
L 00000250 2
L 00000150 2
L 00000050 2
R 00000006 0
# Flush request drops every line
F 00000000 0
L 00000100 0
L 00000450 0
L 00000100 1
# Back to bypass, then enable again
B 00000001 0
L 00000450 0
B 00000000 0
L 00000450 0
S 00000450 1
R 00000004 0

/* verif/icache_tb.sv */
////////////////////////////////////////
// Instruction cache testbench
// Commands come from verif/icache_tests.txt relative to the project root
// Refill memory answers one request at a time with random delays
// Lane k (32 bits) of the line at byte address A holds A + k
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module icache_tb;

   logic              clk;
   logic              rst_n;
   logic              bypass_icache_i;
   logic              flush_icache_i;
   logic              cache_is_bypassed_o;
   logic              cache_is_flushed_o;
   logic              fetch_req_i;
   icache_pkg::addr_t fetch_addr_i;
   logic              fetch_gnt_o;
   logic              fetch_rvalid_o;
   icache_pkg::line_t fetch_rdata_o;
   logic              refill_req_o;
   logic              refill_gnt_i;
   icache_pkg::addr_t refill_addr_o;
   logic              refill_r_valid_i;
   icache_pkg::line_t refill_r_data_i;

   byte               cmd_op [$];
   logic [31:0]       cmd_a [$];
   logic [31:0]       cmd_b [$];
   int                cmd_count = 0;
   int                errors    = 0;
   int                checks    = 0;
   int                accepted  = 0;   // Fetches granted
   int                responses = 0;   // fetch_rvalid_o pulses
   int                refill_count = 0;
   int                refill_mark  = 0;
   icache_pkg::addr_t last_refill_addr;
   integer            seed = 32'h6105806b;

   icache_top DUT (
      .clk                 (clk),
      .rst_n               (rst_n),
      .bypass_icache_i     (bypass_icache_i),
      .flush_icache_i      (flush_icache_i),
      .cache_is_bypassed_o (cache_is_bypassed_o),
      .cache_is_flushed_o  (cache_is_flushed_o),
      .fetch_req_i         (fetch_req_i),
      .fetch_addr_i        (fetch_addr_i),
      .fetch_gnt_o         (fetch_gnt_o),
      .fetch_rvalid_o      (fetch_rvalid_o),
      .fetch_rdata_o       (fetch_rdata_o),
      .refill_req_o        (refill_req_o),
      .refill_gnt_i        (refill_gnt_i),
      .refill_addr_o       (refill_addr_o),
      .refill_r_valid_i    (refill_r_valid_i),
      .refill_r_data_i     (refill_r_data_i)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   //////////////////////////////////////// Helpers
   task automatic report_mismatch(input string msg);
      errors++;
      $display("** Error @ %0t ns: %s", $time, msg);
   endtask

   task automatic report_failure(input string msg);
      errors++;
      $display("Failure at %0t ns: %s", $time, msg);
   endtask

   function automatic icache_pkg::line_t line_data(input icache_pkg::addr_t addr);
      icache_pkg::line_t line;
      icache_pkg::addr_t base;
      base = {addr[31:4], 4'h0};
      for (int k = 0; k < 4; k++)
         line[32*k +: 32] = base + k;
      return line;
   endfunction

   task automatic load_tests();
      int          fd;
      int          rc;
      string       op;
      string       rest;
      logic [31:0] a;
      logic [31:0] b;
      fd = $fopen("verif/icache_tests.txt", "r");
      if (fd == 0)
      begin
         report_failure("cannot open verif/icache_tests.txt");
         return;
      end
      while (!$feof(fd))
      begin
         rc = $fscanf(fd, "%s", op);
         if (rc != 1)
            break;
         if (op.getc(0) == "#")
         begin
            rc = $fgets(rest, fd);   // Skip the comment text
            continue;
         end
         rc = $fscanf(fd, "%h %h", a, b);
         if (rc != 2)
         begin
            report_failure($sformatf("bad arguments for command %s", op));
            break;
         end
         cmd_op.push_back(op.getc(0));
         cmd_a.push_back(a);
         cmd_b.push_back(b);
      end
      $fclose(fd);
   endtask

   task automatic check_refill_held(input icache_pkg::addr_t addr);
      checks++;
      if (!refill_req_o || refill_addr_o !== addr)
         report_mismatch($sformatf("refill of 0x%08h dropped or changed before grant", addr));
      if (fetch_gnt_o)
         report_mismatch("fetch granted while a refill waits for grant");
   endtask

   // Counts negedges from the first flush cycle; a fetch is held pending meanwhile
   task automatic wait_flush_done();
      int cycles;
      cycles = 0;
      do
      begin
         @(negedge clk);
         cycles++;
         if (fetch_gnt_o)
            report_mismatch("fetch granted while tags are cleared");
      end
      while (!cache_is_flushed_o && cycles < 64);
      checks++;
      if (!cache_is_flushed_o)
         report_failure("cache_is_flushed_o never rose after the flush began");
      else if (cycles != 16)
         report_mismatch($sformatf("flush took %0d cycles, expected 16", cycles));
      @(posedge clk);
      fetch_req_i <= 1'b0;
   endtask

   task automatic set_bypass(input logic on);
      int cycles;
      cycles = 0;
      @(posedge clk);
      bypass_icache_i <= on;
      if (on)
      begin
         do
         begin
            @(negedge clk);
            cycles++;
         end
         while (!cache_is_bypassed_o && cycles < 50);
         if (!cache_is_bypassed_o)
            report_failure("cache did not enter bypass");
      end
      else
      begin
         fetch_req_i  <= 1'b1;
         fetch_addr_i <= 32'h0000_7ff0;
         @(posedge clk);
         wait_flush_done();
         @(negedge clk);
         checks++;
         if (cache_is_bypassed_o)
            report_mismatch("cache_is_bypassed_o still high after the cache was enabled");
      end
   endtask

   task automatic request_flush();
      @(posedge clk);
      flush_icache_i <= 1'b1;
      fetch_req_i    <= 1'b1;
      fetch_addr_i   <= 32'h0000_7ff0;
      @(posedge clk);
      flush_icache_i <= 1'b0;
      wait_flush_done();
   endtask

   // Flag 0 expects a miss, 1 a hit and 2 either
   task automatic fetch_line(input icache_pkg::addr_t addr, input logic [31:0] flag);
      int                wait_cnt;
      int                latency;
      int                refills;
      int                refills_before;
      logic              granted;
      icache_pkg::line_t rdata;
      refills_before = refill_count;
      wait_cnt       = 0;
      latency        = 0;
      @(posedge clk);
      fetch_req_i  <= 1'b1;
      fetch_addr_i <= addr;
      do
      begin
         @(negedge clk);
         wait_cnt++;
      end
      while (!fetch_gnt_o && wait_cnt < 100);
      granted = fetch_gnt_o;
      @(posedge clk);
      fetch_req_i <= 1'b0;
      if (!granted)
      begin
         report_failure($sformatf("fetch of 0x%08h was never granted", addr));
         return;
      end
      do
      begin
         @(negedge clk);
         latency++;
      end
      while (!fetch_rvalid_o && latency < 100);
      if (!fetch_rvalid_o)
      begin
         report_failure($sformatf("fetch of 0x%08h was never answered", addr));
         return;
      end
      rdata   = fetch_rdata_o;
      refills = refill_count - refills_before;
      checks++;
      if (rdata !== line_data(addr))
         report_mismatch($sformatf("fetch 0x%08h returned %h, expected %h",
                                   addr, rdata, line_data(addr)));
      if (flag == 1 && (refills != 0 || latency != 1))
         report_mismatch($sformatf("fetch 0x%08h not a hit: %0d refills, latency %0d",
                                   addr, refills, latency));
      if (flag == 0 && refills != 1)
         report_mismatch($sformatf("fetch 0x%08h caused %0d refills, expected 1",
                                   addr, refills));
      else if (flag == 0 && last_refill_addr !== addr)
         report_mismatch($sformatf("refill address 0x%08h for fetch 0x%08h",
                                   last_refill_addr, addr));
      if (flag == 2 && refills > 1)
         report_mismatch($sformatf("fetch 0x%08h caused %0d refills", addr, refills));
   endtask

   // Back-to-back fetches of n consecutive lines that should all hit
   task automatic stream_hits(input icache_pkg::addr_t base, input int n);
      icache_pkg::addr_t pending [$];
      icache_pkg::addr_t exp_addr;
      int                issued;
      int                got;
      int                cycles;
      int                first_gnt;
      int                last_rsp;
      int                refills_before;
      logic              gnt_seen;
      issued         = 0;
      got            = 0;
      cycles         = 0;
      first_gnt      = -1;
      last_rsp       = 0;
      refills_before = refill_count;
      @(posedge clk);
      fetch_req_i  <= 1'b1;
      fetch_addr_i <= base;
      while (got < n && cycles < 100 * n)
      begin
         @(negedge clk);
         cycles++;
         if (fetch_rvalid_o)
         begin
            checks++;
            if (pending.size() == 0)
               report_mismatch("response without a granted fetch");
            else
            begin
               exp_addr = pending.pop_front();
               if (fetch_rdata_o !== line_data(exp_addr))
                  report_mismatch($sformatf("streamed fetch 0x%08h returned %h, expected %h",
                                            exp_addr, fetch_rdata_o, line_data(exp_addr)));
            end
            got++;
            last_rsp = cycles;
         end
         gnt_seen = fetch_req_i && fetch_gnt_o;
         if (gnt_seen)
         begin
            pending.push_back(fetch_addr_i);
            issued++;
            if (first_gnt < 0)
               first_gnt = cycles;
         end
         @(posedge clk);
         if (gnt_seen && issued < n)
            fetch_addr_i <= base + icache_pkg::addr_t'(16 * issued);
         else if (gnt_seen)
            fetch_req_i <= 1'b0;
      end
      checks++;
      if (got < n)
      begin
         report_failure($sformatf("stream from 0x%08h got %0d of %0d responses", base, got, n));
         fetch_req_i <= 1'b0;
      end
      else if (last_rsp - first_gnt != n)
         report_mismatch($sformatf("stream of %0d hits took %0d cycles", n, last_rsp - first_gnt));
      if (refill_count != refills_before)
         report_mismatch("streamed hits caused a refill");
   endtask

   task automatic check_refills(input int max_cnt);
      checks++;
      if (refill_count - refill_mark > max_cnt)
         report_mismatch($sformatf("%0d refills since last mark, at most %0d expected",
                                   refill_count - refill_mark, max_cnt));
      refill_mark = refill_count;
   endtask

   //////////////////////////////////////// Refill memory model
   initial
   begin : refill_model
      icache_pkg::addr_t req_addr;
      int                gnt_wait;
      int                data_wait;
      refill_gnt_i     <= 1'b0;
      refill_r_valid_i <= 1'b0;
      refill_r_data_i  <= '0;
      forever
      begin
         @(negedge clk);
         if (rst_n && refill_req_o)
         begin
            req_addr         = refill_addr_o;
            last_refill_addr = req_addr;
            refill_count++;
            gnt_wait  = $unsigned($random(seed)) % 6;
            data_wait = 1 + $unsigned($random(seed)) % 6;
            repeat (gnt_wait)
            begin
               @(negedge clk);
               check_refill_held(req_addr);
            end
            @(posedge clk);
            refill_gnt_i <= 1'b1;
            @(negedge clk);
            check_refill_held(req_addr);
            @(posedge clk);
            refill_gnt_i <= 1'b0;
            repeat (data_wait - 1)
               @(posedge clk);
            refill_r_valid_i <= 1'b1;
            refill_r_data_i  <= line_data(req_addr);
            @(posedge clk);
            refill_r_valid_i <= 1'b0;
         end
      end
   end

   // One response per accepted fetch and never ahead of the grants
   always @(negedge clk)
   begin
      if (rst_n)
      begin
         if (fetch_req_i && fetch_gnt_o)
            accepted++;
         if (fetch_rvalid_o)
         begin
            responses++;
            if (responses > accepted)
               report_mismatch("fetch_rvalid_o without an accepted fetch");
         end
      end
   end

   initial
   begin : watchdog
      wait (cmd_count > 0);
      repeat ((cmd_count + 1) * 200) @(posedge clk);
      $display("Watchdog: run did not finish within %0d cycles", (cmd_count + 1) * 200);
      $display("Test FAILED");
      $finish;
   end

   //////////////////////////////////////// Main sequence
   initial
   begin : main
      rst_n           <= 1'b0;
      bypass_icache_i <= 1'b1;   // Start in bypass until the command file enables the cache
      flush_icache_i  <= 1'b0;
      fetch_req_i     <= 1'b0;
      fetch_addr_i    <= '0;
      load_tests();
      cmd_count = cmd_op.size();
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      checks++;
      if (!cache_is_bypassed_o || !cache_is_flushed_o || refill_req_o || fetch_rvalid_o)
         report_mismatch("wrong status or strobes after reset");
      for (int i = 0; i < cmd_count; i++)
      begin
         case (cmd_op[i])
            "B": set_bypass(cmd_a[i][0]);
            "F": request_flush();
            "L": fetch_line(cmd_a[i], cmd_b[i]);
            "S": stream_hits(cmd_a[i], cmd_b[i]);
            "I": repeat (cmd_a[i]) @(posedge clk);
            "R": check_refills(cmd_a[i]);
            default: report_failure($sformatf("unknown command %c", cmd_op[i]));
         endcase
      end
      repeat (4) @(posedge clk);
      if (accepted != responses)
         report_mismatch($sformatf("%0d fetches accepted, %0d answered", accepted, responses));
      $display("Errors: %0d, checks: %0d", errors, checks);
      if (errors == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* rtl/icache_top.sv */
////////////////////////////////////////
// Private instruction cache, 128-bit fetch port
// 4 ways x 16 sets x one 128-bit line, arrays held inside
// Starts disabled and bypassed; clearing bypass enables
// the cache after a full tag flush
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "icache_cfg.svh"

module icache_top (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              bypass_icache_i,
   input  logic              flush_icache_i,
   output logic              cache_is_bypassed_o,
   output logic              cache_is_flushed_o,
   // Processor fetch port
   input  logic              fetch_req_i,
   input  icache_pkg::addr_t fetch_addr_i,
   output logic              fetch_gnt_o,
   output logic              fetch_rvalid_o,
   output icache_pkg::line_t fetch_rdata_o,
   // Refill port
   output logic              refill_req_o,
   input  logic              refill_gnt_i,
   output icache_pkg::addr_t refill_addr_o,
   input  logic              refill_r_valid_i,
   input  icache_pkg::line_t refill_r_data_i
);

   icache_pkg::way_vec_t                            tag_req;
   logic                                            tag_we;
   icache_pkg::set_idx_t                            tag_idx;
   icache_pkg::tag_entry_t                          tag_wdata;
   icache_pkg::tag_entry_t [`ICACHE_NB_WAYS-1:0]    tag_rdata;
   icache_pkg::way_vec_t                            data_req;
   logic                                            data_we;
   icache_pkg::set_idx_t                            data_idx;
   icache_pkg::line_t [`ICACHE_NB_WAYS-1:0]         data_rdata;
   icache_pkg::addr_t                               lookup_addr;
   logic                                            hit;
   icache_pkg::way_idx_t                            hit_way;
   logic                                            all_valid;
   icache_pkg::way_vec_t                            victim_way;
   logic                                            victim_take;

   icache_ctrl u_ctrl (
      .clk                 (clk),
      .rst_n               (rst_n),
      .bypass_icache_i     (bypass_icache_i),
      .flush_icache_i      (flush_icache_i),
      .cache_is_bypassed_o (cache_is_bypassed_o),
      .cache_is_flushed_o  (cache_is_flushed_o),
      .fetch_req_i         (fetch_req_i),
      .fetch_addr_i        (fetch_addr_i),
      .fetch_gnt_o         (fetch_gnt_o),
      .fetch_rvalid_o      (fetch_rvalid_o),
      .fetch_rdata_o       (fetch_rdata_o),
      .refill_req_o        (refill_req_o),
      .refill_gnt_i        (refill_gnt_i),
      .refill_addr_o       (refill_addr_o),
      .refill_r_valid_i    (refill_r_valid_i),
      .refill_r_data_i     (refill_r_data_i),
      .tag_req_o           (tag_req),
      .tag_we_o            (tag_we),
      .tag_idx_o           (tag_idx),
      .tag_wdata_o         (tag_wdata),
      .data_req_o          (data_req),
      .data_we_o           (data_we),
      .data_idx_o          (data_idx),
      .data_rdata_i        (data_rdata),
      .lookup_addr_o       (lookup_addr),
      .hit_i               (hit),
      .hit_way_i           (hit_way),
      .all_valid_i         (all_valid),
      .victim_way_i        (victim_way),
      .victim_take_o       (victim_take)
   );

   icache_way_select u_way_select (
      .clk           (clk),
      .rst_n         (rst_n),
      .tag_rdata_i   (tag_rdata),
      .lookup_addr_i (lookup_addr),
      .victim_take_i (victim_take),
      .hit_o         (hit),
      .hit_way_o     (hit_way),
      .all_valid_o   (all_valid),
      .victim_way_o  (victim_way)
   );

   //////////////////////////////////////// Tag and data ways
   for (genvar w = 0; w < `ICACHE_NB_WAYS; w++)
   begin : g_way
      icache_array #(
         .entry_t (icache_pkg::tag_entry_t)
      ) u_tag (
         .clk     (clk),
         .rst_n   (rst_n),
         .req_i   (tag_req[w]),
         .we_i    (tag_we),
         .idx_i   (tag_idx),
         .wdata_i (tag_wdata),
         .rdata_o (tag_rdata[w])
      );

      // Refill beat is written as is
      icache_array #(
         .entry_t (icache_pkg::line_t)
      ) u_data (
         .clk     (clk),
         .rst_n   (rst_n),
         .req_i   (data_req[w]),
         .we_i    (data_we),
         .idx_i   (data_idx),
         .wdata_i (refill_r_data_i),
         .rdata_o (data_rdata[w])
      );
   end

endmodule

`default_nettype wire

/* rtl/icache_ctrl.sv */
////////////////////////////////////////
// Instruction cache controller FSM
// Bypass, full flush, lookup and single-beat refill
// Refill memory must return exactly one beat per request
// Bypass/flush requests are taken in IDLE only
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "icache_cfg.svh"

module icache_ctrl (
   input  logic                                     clk,
   input  logic                                     rst_n,
   input  logic                                     bypass_icache_i,
   input  logic                                     flush_icache_i,
   output logic                                     cache_is_bypassed_o,
   output logic                                     cache_is_flushed_o,
   input  logic                                     fetch_req_i,
   input  icache_pkg::addr_t                        fetch_addr_i,
   output logic                                     fetch_gnt_o,
   output logic                                     fetch_rvalid_o,
   output icache_pkg::line_t                        fetch_rdata_o,
   output logic                                     refill_req_o,
   input  logic                                     refill_gnt_i,
   output icache_pkg::addr_t                        refill_addr_o,
   input  logic                                     refill_r_valid_i,
   input  icache_pkg::line_t                        refill_r_data_i,
   output icache_pkg::way_vec_t                     tag_req_o,
   output logic                                     tag_we_o,
   output icache_pkg::set_idx_t                     tag_idx_o,
   output icache_pkg::tag_entry_t                   tag_wdata_o,
   output icache_pkg::way_vec_t                     data_req_o,
   output logic                                     data_we_o,
   output icache_pkg::set_idx_t                     data_idx_o,
   input  icache_pkg::line_t [`ICACHE_NB_WAYS-1:0]  data_rdata_i,
   output icache_pkg::addr_t                        lookup_addr_o,
   input  logic                                     hit_i,
   input  icache_pkg::way_idx_t                     hit_way_i,
   input  logic                                     all_valid_i,
   input  icache_pkg::way_vec_t                     victim_way_i,
   output logic                                     victim_take_o
);

   icache_pkg::ctrl_state_e state_q, state_d;
   icache_pkg::addr_t       lookup_addr_q;
   icache_pkg::set_idx_t    flush_cnt_q;
   icache_pkg::way_vec_t    refill_way_q;
   icache_pkg::set_idx_t    fetch_set;
   icache_pkg::set_idx_t    lookup_set;
   logic                    bypass_pend_q;   // Bypassed fetch still waiting for data
   logic                    fetch_acc;
   logic                    save_way;

   assign fetch_acc     = fetch_req_i & fetch_gnt_o;
   assign fetch_set     = fetch_addr_i[`ICACHE_SET_LSB +: `ICACHE_SET_W];
   assign lookup_set    = lookup_addr_q[`ICACHE_SET_LSB +: `ICACHE_SET_W];
   assign lookup_addr_o = lookup_addr_q;

   always_ff @(posedge clk, negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q       <= icache_pkg::DISABLED;
         lookup_addr_q <= '0;
         flush_cnt_q   <= '0;
         refill_way_q  <= '0;
         bypass_pend_q <= 1'b0;
      end
      else
      begin
         state_q <= state_d;
         if (fetch_acc)
            lookup_addr_q <= fetch_addr_i;
         if (save_way)
            refill_way_q <= victim_way_i;
         // Counter wraps to zero on the last flush cycle
         if (state_q == icache_pkg::FLUSH)
            flush_cnt_q <= flush_cnt_q + 1'b1;
         else
            flush_cnt_q <= '0;
         if (state_q == icache_pkg::DISABLED || state_q == icache_pkg::BYPASS_DELAY)
         begin
            if (fetch_acc)
               bypass_pend_q <= 1'b1;
            else if (refill_r_valid_i)
               bypass_pend_q <= 1'b0;
         end
      end
   end

   //////////////////////////////////////// Next state and outputs
   always_comb
   begin
      state_d             = state_q;
      fetch_gnt_o         = 1'b0;
      fetch_rvalid_o      = 1'b0;
      fetch_rdata_o       = refill_r_data_i;
      refill_req_o        = 1'b0;
      refill_addr_o       = lookup_addr_q;
      tag_req_o           = '0;
      tag_we_o            = 1'b0;
      tag_idx_o           = fetch_set;
      tag_wdata_o         = {1'b1, lookup_addr_q[`ICACHE_TAG_LSB +: `ICACHE_TAG_W]};
      data_req_o          = '0;
      data_we_o           = 1'b0;
      data_idx_o          = fetch_set;
      cache_is_bypassed_o = 1'b0;
      cache_is_flushed_o  = 1'b0;
      save_way            = 1'b0;
      victim_take_o       = 1'b0;

      case (state_q)
         icache_pkg::DISABLED:
         begin
            cache_is_bypassed_o = 1'b1;
            cache_is_flushed_o  = 1'b1;
            fetch_rvalid_o      = refill_r_valid_i;   // Single beat passes straight through
            if (bypass_icache_i)
            begin
               fetch_gnt_o = fetch_req_i;
               if (fetch_req_i)
                  state_d = icache_pkg::BYPASS_DELAY;
            end
            else if (!bypass_pend_q)
               state_d = icache_pkg::FLUSH;
         end

         icache_pkg::BYPASS_DELAY:
         begin
            cache_is_bypassed_o = 1'b1;
            cache_is_flushed_o  = 1'b1;
            fetch_rvalid_o      = refill_r_valid_i;
            refill_req_o        = 1'b1;
            if (refill_gnt_i)
               state_d = icache_pkg::DISABLED;
         end

         icache_pkg::FLUSH:
         begin
            tag_req_o   = '1;
            tag_we_o    = 1'b1;
            tag_idx_o   = flush_cnt_q;
            tag_wdata_o = '0;
            if (&flush_cnt_q)
            begin
               cache_is_flushed_o = 1'b1;
               state_d            = icache_pkg::IDLE;
            end
         end

         icache_pkg::IDLE:
         begin
            if (bypass_icache_i)
               state_d = icache_pkg::DISABLED;
            else if (flush_icache_i)
               state_d = icache_pkg::FLUSH;
            else
            begin
               fetch_gnt_o = fetch_req_i;
               tag_req_o   = {`ICACHE_NB_WAYS{fetch_req_i}};
               data_req_o  = {`ICACHE_NB_WAYS{fetch_req_i}};
               if (fetch_req_i)
                  state_d = icache_pkg::LOOKUP;
            end
         end

         icache_pkg::LOOKUP:
         begin
            if (hit_i)
            begin
               fetch_rvalid_o = 1'b1;
               fetch_rdata_o  = data_rdata_i[hit_way_i];
               // Next fetch streams in unless a control request is pending
               fetch_gnt_o    = fetch_req_i & ~bypass_icache_i & ~flush_icache_i;
               tag_req_o      = {`ICACHE_NB_WAYS{fetch_gnt_o}};
               data_req_o     = {`ICACHE_NB_WAYS{fetch_gnt_o}};
               state_d        = fetch_gnt_o ? icache_pkg::LOOKUP : icache_pkg::IDLE;
            end
            else
            begin
               refill_req_o  = 1'b1;
               save_way      = 1'b1;
               victim_take_o = all_valid_i;   // Only random picks move the LFSR
               state_d       = refill_gnt_i ? icache_pkg::WAIT_DONE : icache_pkg::WAIT_GNT;
            end
         end

         icache_pkg::WAIT_GNT:
         begin
            refill_req_o = 1'b1;
            if (refill_gnt_i)
               state_d = icache_pkg::WAIT_DONE;
         end

         icache_pkg::WAIT_DONE:
         begin
            fetch_rvalid_o = refill_r_valid_i;
            tag_req_o      = refill_way_q & {`ICACHE_NB_WAYS{refill_r_valid_i}};
            tag_we_o       = 1'b1;
            tag_idx_o      = lookup_set;
            data_req_o     = refill_way_q & {`ICACHE_NB_WAYS{refill_r_valid_i}};
            data_we_o      = 1'b1;
            data_idx_o     = lookup_set;
            if (refill_r_valid_i)
               state_d = icache_pkg::IDLE;
         end

         default:
            state_d = icache_pkg::DISABLED;
      endcase
   end

endmodule

`default_nettype wire

/* rtl/icache_way_select.sv */
////////////////////////////////////////
// Tag compare and victim choice
// Lowest invalid way is filled first; with all ways valid
// an 8-bit LFSR picks the victim
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "icache_cfg.svh"

module icache_way_select (
   input  logic                                          clk,
   input  logic                                          rst_n,
   input  icache_pkg::tag_entry_t [`ICACHE_NB_WAYS-1:0]  tag_rdata_i,
   input  icache_pkg::addr_t                             lookup_addr_i,
   input  logic                                          victim_take_i,
   output logic                                          hit_o,
   output icache_pkg::way_idx_t                          hit_way_o,
   output logic                                          all_valid_o,
   output icache_pkg::way_vec_t                          victim_way_o
);

   icache_pkg::way_vec_t way_valid;
   icache_pkg::way_vec_t way_match;
   icache_pkg::way_idx_t free_idx;
   icache_pkg::way_idx_t rnd_idx;
   logic [7:0]           lfsr_q;

   for (genvar w = 0; w < `ICACHE_NB_WAYS; w++)
   begin : g_cmp
      assign way_valid[w] = tag_rdata_i[w][`ICACHE_TAG_W];
      assign way_match[w] = way_valid[w] &&
         (tag_rdata_i[w][`ICACHE_TAG_W-1:0] == lookup_addr_i[`ICACHE_TAG_LSB +: `ICACHE_TAG_W]);
   end

   assign hit_o       = |way_match;
   assign all_valid_o = &way_valid;

   // Lowest index wins for both searches
   always_comb
   begin
      hit_way_o = '0;
      free_idx  = '0;
      for (int i = `ICACHE_NB_WAYS - 1; i >= 0; i--)
      begin
         if (way_match[i])
            hit_way_o = icache_pkg::way_idx_t'(i);
         if (!way_valid[i])
            free_idx = icache_pkg::way_idx_t'(i);
      end
   end

   assign rnd_idx      = lfsr_q[$bits(icache_pkg::way_idx_t)-1:0];
   assign victim_way_o = all_valid_o ? icache_pkg::way_vec_t'(1) << rnd_idx
                                     : icache_pkg::way_vec_t'(1) << free_idx;

   //////////////////////////////////////// Replacement LFSR
   // x^8 + x^6 + x^5 + x^4 + 1
   always_ff @(posedge clk, negedge rst_n)
   begin
      if (!rst_n)
         lfsr_q <= `ICACHE_LFSR_SEED;
      else if (victim_take_i && all_valid_o)
         lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
   end

endmodule

`default_nettype wire

/* rtl/icache_array.sv */
////////////////////////////////////////
// Single-port set-indexed array, one way
// Read data appears one cycle after a read request
// and holds until the next read
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "icache_cfg.svh"

module icache_array #(
   parameter type entry_t = logic
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 req_i,
   input  logic                 we_i,
   input  icache_pkg::set_idx_t idx_i,
   input  entry_t               wdata_i,
   output entry_t               rdata_o
);

   entry_t mem [`ICACHE_NB_SETS];

   always_ff @(posedge clk)
   begin
      if (req_i && we_i)
         mem[idx_i] <= wdata_i;
   end

   // Registered read port
   always_ff @(posedge clk, negedge rst_n)
   begin
      if (!rst_n)
         rdata_o <= '0;
      else if (req_i && !we_i)
         rdata_o <= mem[idx_i];
   end

endmodule

`default_nettype wire

/* rtl/icache_pkg.sv */
////////////////////////////////////////
// Types shared by the instruction cache
// Tag entry layout is {valid, tag}
////////////////////////////////////////

`default_nettype none

`include "icache_cfg.svh"

package icache_pkg;

   typedef logic [`ICACHE_ADDR_W-1:0]          addr_t;
   typedef logic [`ICACHE_LINE_W-1:0]          line_t;
   typedef logic [`ICACHE_SET_W-1:0]           set_idx_t;
   typedef logic [`ICACHE_TAG_W:0]             tag_entry_t;   // MSB is the valid bit
   typedef logic [`ICACHE_NB_WAYS-1:0]         way_vec_t;
   typedef logic [$clog2(`ICACHE_NB_WAYS)-1:0] way_idx_t;

   // Controller states
   typedef enum logic [2:0] {
      DISABLED,
      BYPASS_DELAY,
      FLUSH,
      IDLE,
      LOOKUP,
      WAIT_GNT,
      WAIT_DONE
   } ctrl_state_e;

endpackage

`default_nettype wire

/* rtl/icache_cfg.svh */
////////////////////////////////////////
// Instruction cache geometry and address fields
// Four ways, 16 sets, one 128-bit line per set
// Only address bits 14:4 are used by the cache; bits above
// bit 14 are not stored, so lines alias across 32 KB
// LFSR seed must be non-zero
////////////////////////////////////////

`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

`define ICACHE_ADDR_W    32
`define ICACHE_LINE_W    128
`define ICACHE_NB_WAYS   4
`define ICACHE_NB_SETS   16

// Address split: | unused | tag | set | offset |
`define ICACHE_OFFSET_W  4
`define ICACHE_SET_LSB   `ICACHE_OFFSET_W
`define ICACHE_SET_W     4
`define ICACHE_TAG_LSB   (`ICACHE_SET_LSB + `ICACHE_SET_W)
`define ICACHE_TAG_W     7

`define ICACHE_LFSR_SEED 8'hA5

`endif
